//--- vlog.f
src/fractal_pkg.sv
src/axil_regfile.sv
src/pixel_scan.sv
src/mandel_core.sv
src/core_dispatch.sv
src/pixel_stream_out.sv
src/pixel_generator.sv
sim/tb_pixel_generator.sv

//--- sim/tb_pixel_generator.sv
// testbench of the Mandelbrot pixel generator
// AXI-Lite driver, escape-count reference model and expected beat queue
// assertions on idle state, register readback, pixel order and stream hold
`timescale 1ns/1ps

module tb_pixel_generator;

    localparam int IMG_W    = 6;
    localparam int IMG_H    = 3;
    localparam int MAX_ITER = 20;
    localparam int FRAMES   = 2;
    localparam int TOTAL    = FRAMES * IMG_W * IMG_H;
    localparam int TIMEOUT_CYCLES = TOTAL * (MAX_ITER + 8) * 4 + 2000;
    localparam int START_X  = 32'hFE00_0000;     // -2.0
    localparam int START_Y  = 32'h0080_0000;     // 0.5
    localparam int STEP     = 32'h0080_0000;     // 0.5

    logic        out_stream_aclk = 1'b0;
    logic        axi_resetn;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rready;
    logic [31:0] tdata;
    logic [3:0]  tkeep;
    logic        tlast;
    logic [0:0]  tuser;
    logic        tvalid;
    logic        tready = 1'b0;

    integer      seed = 34;
    int          errors = 0;
    int          beats = 0;
    int          reads = 0;
    int          cycles = 0;
    logic        stream_on = 1'b0;
    logic        run_written = 1'b0;
    logic        hold_armed = 1'b0;
    logic [34:0] held_word;
    logic [33:0] exp_word;
    logic [33:0] expected_q[$];

    always #10 out_stream_aclk = ~out_stream_aclk;

    pixel_generator i_dut (
        .out_stream_aclk, .axi_resetn,
        .s_axi_lite_awaddr_i(awaddr), .s_axi_lite_awvalid_i(awvalid),
        .s_axi_lite_awready_o(awready),
        .s_axi_lite_wdata_i(wdata), .s_axi_lite_wvalid_i(wvalid), .s_axi_lite_wready_o(wready),
        .s_axi_lite_bvalid_o(bvalid), .s_axi_lite_bresp_o(bresp), .s_axi_lite_bready_i(bready),
        .s_axi_lite_araddr_i(araddr), .s_axi_lite_arvalid_i(arvalid),
        .s_axi_lite_arready_o(arready),
        .s_axi_lite_rvalid_o(rvalid), .s_axi_lite_rdata_o(rdata), .s_axi_lite_rresp_o(rresp),
        .s_axi_lite_rready_i(rready),
        .out_stream_tdata_o(tdata), .out_stream_tkeep_o(tkeep), .out_stream_tlast_o(tlast),
        .out_stream_tuser_o(tuser), .out_stream_tvalid_o(tvalid), .out_stream_tready_i(tready)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    function automatic int escape_count(input int c_re, input int c_im, input int limit);
        longint z_re;
        longint z_im;
        longint rr;
        longint ii;
        longint ri;
        z_re = 0;
        z_im = 0;
        for (int n = 0; n < limit; n++) begin
            rr = (z_re * z_re) >>> 24;
            ii = (z_im * z_im) >>> 24;
            if (rr + ii > (64'sd4 <<< 24)) return n;   // escaped
            ri = (z_re * z_im) >>> 24;
            z_re = longint'(int'(rr - ii + c_re));     // 32-bit wrap
            z_im = longint'(int'(2 * ri + c_im));
        end
        return limit;
    endfunction

    function automatic logic [33:0] pixel_word(input int count, input bit first, input bit last);
        logic [15:0] n;
        n = 16'(count);
        return {last, first, 8'h00, n[7:0], n[7:0], n[15:8]};
    endfunction

    task automatic build_expected();
        int re;
        int im;
        for (int f = 0; f < FRAMES; f++) begin
            for (int y = 0; y < IMG_H; y++) begin
                for (int x = 0; x < IMG_W; x++) begin
                    re = START_X + x * STEP;
                    im = START_Y - y * STEP;             // rows step downward
                    expected_q.push_back(pixel_word(escape_count(re, im, MAX_ITER),
                                                    x == 0 && y == 0, x == IMG_W - 1));
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI-Lite driver with order 0 address first, 1 data first, 2 together
    task automatic write_reg(input int order, input int idx, input logic [31:0] data);
        bit aw_left;
        bit w_left;
        aw_left = 1'b1;
        w_left  = 1'b1;
        @(posedge out_stream_aclk);
        awaddr  <= 8'(idx * 4);
        wdata   <= data;
        awvalid <= (order != 1);
        wvalid  <= (order != 0);
        while (aw_left || w_left) begin
            @(posedge out_stream_aclk);
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                aw_left = 1'b0;
                if (w_left) wvalid <= 1'b1;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;
                w_left = 1'b0;
                if (aw_left) awvalid <= 1'b1;
            end
        end
        bready <= 1'b1;
        do @(posedge out_stream_aclk); while (!(bvalid && bready));
        bready <= 1'b0;
        assert (bresp == fractal_pkg::AXI_RESP_OKAY) else begin
            errors++;
            $display("ERROR bresp: expected %b, actual %b", fractal_pkg::AXI_RESP_OKAY, bresp);
        end
    endtask

    task automatic read_reg(input int idx, output logic [31:0] data);
        @(posedge out_stream_aclk);
        araddr  <= 8'(idx * 4);
        arvalid <= 1'b1;
        do @(posedge out_stream_aclk); while (!arready);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        do @(posedge out_stream_aclk); while (!(rvalid && rready));
        rready <= 1'b0;
        data = rdata;
        reads++;
        assert (rresp == fractal_pkg::AXI_RESP_OKAY) else begin
            errors++;
            $display("ERROR rresp: expected %b, actual %b", fractal_pkg::AXI_RESP_OKAY, rresp);
        end
    endtask

    task automatic print_summary();
        $display("beats %0d of %0d, register reads %0d, errors %0d", beats, TOTAL, reads, errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // checkers
    a_idle_stream: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        !run_written |-> !tvalid)
        else begin
            errors++;
            $display("stream offered a beat before the generator was started");
        end

    always @(posedge out_stream_aclk) begin
        if (axi_resetn && tvalid && tready) begin
            exp_word = expected_q.pop_front();
            assert ({tlast, tuser, tdata} == exp_word) else begin
                errors++;
                $display("ERROR pixels beat %0d: expected %h, actual %h",
                         beats, exp_word, {tlast, tuser, tdata});
            end
            assert (tkeep == 4'hf) else begin
                errors++;
                $display("ERROR tkeep: expected f, actual %h", tkeep);
            end
            beats++;
        end
    end

    // a stalled beat must not change
    always @(posedge out_stream_aclk) begin
        if (hold_armed) begin
            assert ({tvalid, tlast, tuser, tdata} == held_word) else begin
                errors++;
                $display("ERROR hold: expected %h, actual %h",
                         held_word, {tvalid, tlast, tuser, tdata});
            end
        end
        hold_armed <= axi_resetn && tvalid && !tready;
        held_word  <= {tvalid, tlast, tuser, tdata};
    end

    always @(posedge out_stream_aclk) begin
        if (stream_on) tready <= ($random(seed) & 3) != 0;  // ready about 3 in 4
        else tready <= 1'b1;
    end

    always @(posedge out_stream_aclk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the stream did not deliver every pixel", cycles);
            print_summary();
            $display("Test FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    initial begin
        logic [31:0] data;
        logic [31:0] rd;
        axi_resetn <= 1'b0;
        awaddr     <= '0;
        awvalid    <= 1'b0;
        wdata      <= '0;
        wvalid     <= 1'b0;
        bready     <= 1'b0;
        araddr     <= '0;
        arvalid    <= 1'b0;
        rready     <= 1'b0;
        repeat (10) @(posedge out_stream_aclk);
        axi_resetn <= 1'b1;
        @(posedge out_stream_aclk);
        @(negedge out_stream_aclk);
        assert ({tvalid, bvalid, rvalid} == 3'b000) else begin
            errors++;
            $display("ERROR reset: expected 000, actual %b", {tvalid, bvalid, rvalid});
        end

        // every register in all three write orders with the run bit kept low
        for (int i = 0; i < fractal_pkg::REG_COUNT; i++) begin
            data = $random(seed);
            if (i == fractal_pkg::REG_CTRL) data[0] = 1'b0;
            write_reg(i % 3, i, data);
            read_reg(i, rd);
            assert (rd == data) else begin
                errors++;
                $display("ERROR regs %0d: expected %h, actual %h", i, data, rd);
            end
        end
        repeat (20) @(posedge out_stream_aclk);

        write_reg(0, fractal_pkg::REG_START_X, START_X);
        write_reg(1, fractal_pkg::REG_START_Y, START_Y);
        write_reg(2, fractal_pkg::REG_STEP, STEP);
        write_reg(0, fractal_pkg::REG_MAX_ITER, MAX_ITER);
        write_reg(1, fractal_pkg::REG_SIZE, {16'(IMG_H), 16'(IMG_W)});
        build_expected();
        stream_on <= 1'b1;
        write_reg(2, fractal_pkg::REG_CTRL, 32'h1);
        run_written <= 1'b1;

        while (beats < TOTAL) @(negedge out_stream_aclk);
        print_summary();
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- src/pixel_generator.sv
// top level of the Mandelbrot pixel generator
// register file, scanner, dispatcher, core bank and stream output
`timescale 1ns/1ps

module pixel_generator (
    input  logic                                   out_stream_aclk,
    input  logic                                   axi_resetn,
    input  logic [fractal_pkg::AXIL_ADDR_WIDTH-1:0] s_axi_lite_awaddr_i,
    input  logic                                   s_axi_lite_awvalid_i,
    output logic                                   s_axi_lite_awready_o,
    input  logic [31:0]                            s_axi_lite_wdata_i,
    input  logic                                   s_axi_lite_wvalid_i,
    output logic                                   s_axi_lite_wready_o,
    output logic                                   s_axi_lite_bvalid_o,
    output logic [1:0]                             s_axi_lite_bresp_o,
    input  logic                                   s_axi_lite_bready_i,
    input  logic [fractal_pkg::AXIL_ADDR_WIDTH-1:0] s_axi_lite_araddr_i,
    input  logic                                   s_axi_lite_arvalid_i,
    output logic                                   s_axi_lite_arready_o,
    output logic                                   s_axi_lite_rvalid_o,
    output logic [31:0]                            s_axi_lite_rdata_o,
    output logic [1:0]                             s_axi_lite_rresp_o,
    input  logic                                   s_axi_lite_rready_i,
    output logic [31:0]                            out_stream_tdata_o,
    output logic [3:0]                             out_stream_tkeep_o,
    output logic                                   out_stream_tlast_o,
    output logic [0:0]                             out_stream_tuser_o,
    output logic                                   out_stream_tvalid_o,
    input  logic                                   out_stream_tready_i
);

    logic                                      run;
    logic signed [fractal_pkg::DATA_WIDTH-1:0] start_x;
    logic signed [fractal_pkg::DATA_WIDTH-1:0] start_y;
    logic signed [fractal_pkg::DATA_WIDTH-1:0] step;
    logic [fractal_pkg::ITER_WIDTH-1:0]        max_iter;
    logic [fractal_pkg::COORD_WIDTH-1:0]       size_x;
    logic [fractal_pkg::COORD_WIDTH-1:0]       size_y;
    logic signed [fractal_pkg::DATA_WIDTH-1:0] scan_re;
    logic signed [fractal_pkg::DATA_WIDTH-1:0] scan_im;
    logic signed [fractal_pkg::DATA_WIDTH-1:0] core_re;
    logic signed [fractal_pkg::DATA_WIDTH-1:0] core_im;
    logic                                      scan_first;
    logic                                      scan_last_x;
    logic                                      advance;
    logic [fractal_pkg::CORE_COUNT-1:0]        core_start;
    logic [fractal_pkg::CORE_COUNT-1:0]        core_done;
    logic [fractal_pkg::CORE_COUNT-1:0][fractal_pkg::ITER_WIDTH-1:0] core_iter;
    logic                                      load;
    logic                                      can_accept;
    logic [fractal_pkg::ITER_WIDTH-1:0]        pix_iter;
    logic                                      pix_first;
    logic                                      pix_last;

    axil_regfile i_regfile (
        .out_stream_aclk, .axi_resetn,
        .s_axi_lite_awaddr_i, .s_axi_lite_awvalid_i, .s_axi_lite_awready_o,
        .s_axi_lite_wdata_i, .s_axi_lite_wvalid_i, .s_axi_lite_wready_o,
        .s_axi_lite_bvalid_o, .s_axi_lite_bresp_o, .s_axi_lite_bready_i,
        .s_axi_lite_araddr_i, .s_axi_lite_arvalid_i, .s_axi_lite_arready_o,
        .s_axi_lite_rvalid_o, .s_axi_lite_rdata_o, .s_axi_lite_rresp_o,
        .s_axi_lite_rready_i,
        .run_o(run), .start_x_o(start_x), .start_y_o(start_y), .step_o(step),
        .max_iter_o(max_iter), .size_x_o(size_x), .size_y_o(size_y)
    );

    pixel_scan i_scan (
        .out_stream_aclk, .axi_resetn,
        .run_i(run), .advance_i(advance),
        .start_x_i(start_x), .start_y_i(start_y), .step_i(step),
        .size_x_i(size_x), .size_y_i(size_y),
        .c_re_o(scan_re), .c_im_o(scan_im), .first_o(scan_first), .last_x_o(scan_last_x)
    );

    core_dispatch i_dispatch (
        .out_stream_aclk, .axi_resetn,
        .run_i(run), .c_re_i(scan_re), .c_im_i(scan_im),
        .first_i(scan_first), .last_x_i(scan_last_x),
        .done_i(core_done), .iter_i(core_iter), .can_accept_i(can_accept),
        .advance_o(advance), .start_o(core_start), .c_re_o(core_re), .c_im_o(core_im),
        .load_o(load), .pix_iter_o(pix_iter), .pix_first_o(pix_first), .pix_last_o(pix_last)
    );

    // peer cores sharing one coordinate bus
    for (genvar g = 0; g < fractal_pkg::CORE_COUNT; g++) begin : g_core
        mandel_core i_core (
            .out_stream_aclk, .axi_resetn,
            .start_i(core_start[g]), .c_re_i(core_re), .c_im_i(core_im),
            .max_iter_i(max_iter), .done_o(core_done[g]), .iter_o(core_iter[g])
        );
    end

    pixel_stream_out i_out (
        .out_stream_aclk, .axi_resetn,
        .load_i(load), .pix_iter_i(pix_iter), .pix_first_i(pix_first), .pix_last_i(pix_last),
        .out_stream_tready_i, .can_accept_o(can_accept),
        .out_stream_tdata_o, .out_stream_tkeep_o, .out_stream_tlast_o,
        .out_stream_tuser_o, .out_stream_tvalid_o
    );

endmodule

//--- src/pixel_stream_out.sv
// one-entry AXI-Stream output register
// count to RGB mapping, tuser on first pixel, tlast at end of row
`timescale 1ns/1ps

module pixel_stream_out (
    input  logic                               out_stream_aclk,
    input  logic                               axi_resetn,
    input  logic                               load_i,
    input  logic [fractal_pkg::ITER_WIDTH-1:0] pix_iter_i,
    input  logic                               pix_first_i,
    input  logic                               pix_last_i,
    input  logic                               out_stream_tready_i,
    output logic                               can_accept_o,
    output logic [31:0]                        out_stream_tdata_o,
    output logic [3:0]                         out_stream_tkeep_o,
    output logic                               out_stream_tlast_o,
    output logic [0:0]                         out_stream_tuser_o,
    output logic                               out_stream_tvalid_o
);

    assign can_accept_o       = !out_stream_tvalid_o || out_stream_tready_i;
    assign out_stream_tkeep_o = 4'hf;

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            out_stream_tvalid_o <= 1'b0;
        end else if (load_i) begin
            out_stream_tvalid_o <= 1'b1;
        end else if (out_stream_tready_i) begin
            out_stream_tvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (load_i) begin
            // {0, r, g, b} with r = g = low byte, b = high byte
            out_stream_tdata_o <= {8'h00, pix_iter_i[7:0], pix_iter_i[7:0], pix_iter_i[15:8]};
            out_stream_tuser_o <= pix_first_i;
            out_stream_tlast_o <= pix_last_i;
        end
    end

endmodule

//--- src/core_dispatch.sv
// round-robin dispatcher of the Mandelbrot cores
// fill phase starts every core once, then results are collected in
// the same rotation and each core restarts with the next pixel
`timescale 1ns/1ps

module core_dispatch (
    input  logic                                      out_stream_aclk,
    input  logic                                      axi_resetn,
    input  logic                                      run_i,
    input  logic signed [fractal_pkg::DATA_WIDTH-1:0] c_re_i,
    input  logic signed [fractal_pkg::DATA_WIDTH-1:0] c_im_i,
    input  logic                                      first_i,
    input  logic                                      last_x_i,
    input  logic [fractal_pkg::CORE_COUNT-1:0]        done_i,
    input  logic [fractal_pkg::CORE_COUNT-1:0][fractal_pkg::ITER_WIDTH-1:0] iter_i,
    input  logic                                      can_accept_i,
    output logic                                      advance_o,
    output logic [fractal_pkg::CORE_COUNT-1:0]        start_o,
    output logic signed [fractal_pkg::DATA_WIDTH-1:0] c_re_o,
    output logic signed [fractal_pkg::DATA_WIDTH-1:0] c_im_o,
    output logic                                      load_o,
    output logic [fractal_pkg::ITER_WIDTH-1:0]        pix_iter_o,
    output logic                                      pix_first_o,
    output logic                                      pix_last_o
);

    logic                                  filling;
    logic                                  collect;
    logic                                  go;
    logic [fractal_pkg::CORE_IDX_WIDTH-1:0] ptr;
    logic [fractal_pkg::CORE_COUNT-1:0]    first_q;  // flags of the pixel in each core
    logic [fractal_pkg::CORE_COUNT-1:0]    last_q;

    // the core at ptr owns the output stream until its result leaves
    assign collect = !filling && done_i[ptr] && can_accept_i;
    assign go      = run_i && (filling || collect);

    assign advance_o = go;
    assign load_o    = run_i && collect;
    assign start_o   = go ? (fractal_pkg::CORE_COUNT'(1) << ptr) : '0;
    assign c_re_o    = c_re_i;                    // cores latch on own start
    assign c_im_o    = c_im_i;

    assign pix_iter_o  = iter_i[ptr];
    assign pix_first_o = first_q[ptr];
    assign pix_last_o  = last_q[ptr];

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn || !run_i) begin
            filling <= 1'b1;
            ptr     <= '0;
        end else if (go) begin
            if (ptr == fractal_pkg::CORE_COUNT - 1) begin
                ptr     <= '0;
                filling <= 1'b0;                  // all cores busy now
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (go) begin
            first_q[ptr] <= first_i;
            last_q[ptr]  <= last_x_i;
        end
    end

endmodule

//--- src/mandel_core.sv
// iterative Mandelbrot escape-count engine, one step per cycle
`timescale 1ns/1ps

module mandel_core (
    input  logic                                      out_stream_aclk,
    input  logic                                      axi_resetn,
    input  logic                                      start_i,
    input  logic signed [fractal_pkg::DATA_WIDTH-1:0] c_re_i,
    input  logic signed [fractal_pkg::DATA_WIDTH-1:0] c_im_i,
    input  logic [fractal_pkg::ITER_WIDTH-1:0]        max_iter_i,
    output logic                                      done_o,
    output logic [fractal_pkg::ITER_WIDTH-1:0]        iter_o
);

    logic                                             busy;
    logic                                             stop;
    logic signed [fractal_pkg::DATA_WIDTH-1:0]        z_re;
    logic signed [fractal_pkg::DATA_WIDTH-1:0]        z_im;
    logic signed [fractal_pkg::DATA_WIDTH-1:0]        c_re;
    logic signed [fractal_pkg::DATA_WIDTH-1:0]        c_im;
    logic signed [2*fractal_pkg::DATA_WIDTH-1:0]      rr_full;
    logic signed [2*fractal_pkg::DATA_WIDTH-1:0]      ii_full;
    logic signed [2*fractal_pkg::DATA_WIDTH-1:0]      ri_full;

    // products back in FRAC_BITS scale, integer part kept wide
    logic signed [2*fractal_pkg::DATA_WIDTH-fractal_pkg::FRAC_BITS-1:0] rr;
    logic signed [2*fractal_pkg::DATA_WIDTH-fractal_pkg::FRAC_BITS-1:0] ii;
    logic signed [2*fractal_pkg::DATA_WIDTH-fractal_pkg::FRAC_BITS-1:0] ri;
    logic signed [2*fractal_pkg::DATA_WIDTH-fractal_pkg::FRAC_BITS-1:0] re_nxt;
    logic signed [2*fractal_pkg::DATA_WIDTH-fractal_pkg::FRAC_BITS-1:0] im_nxt;
    logic [2*fractal_pkg::DATA_WIDTH-fractal_pkg::FRAC_BITS:0]          mag;

    assign rr_full = z_re * z_re;
    assign ii_full = z_im * z_im;
    assign ri_full = z_re * z_im;
    assign rr = rr_full[2*fractal_pkg::DATA_WIDTH-1:fractal_pkg::FRAC_BITS];
    assign ii = ii_full[2*fractal_pkg::DATA_WIDTH-1:fractal_pkg::FRAC_BITS];
    assign ri = ri_full[2*fractal_pkg::DATA_WIDTH-1:fractal_pkg::FRAC_BITS];

    assign mag    = {1'b0, rr} + {1'b0, ii};      // both squares non-negative
    assign re_nxt = rr - ii + c_re;
    assign im_nxt = ri + ri + c_im;
    assign stop   = (mag > fractal_pkg::ESCAPE_LIMIT) || (iter_o == max_iter_i);

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            busy   <= 1'b0;
            done_o <= 1'b0;
        end else if (start_i) begin
            busy   <= 1'b1;
            done_o <= 1'b0;
        end else if (busy && stop) begin
            busy   <= 1'b0;
            done_o <= 1'b1;                       // held until next start
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (start_i) begin
            z_re   <= '0;
            z_im   <= '0;
            c_re   <= c_re_i;
            c_im   <= c_im_i;
            iter_o <= '0;
        end else if (busy && !stop) begin
            z_re   <= re_nxt[fractal_pkg::DATA_WIDTH-1:0];
            z_im   <= im_nxt[fractal_pkg::DATA_WIDTH-1:0];
            iter_o <= iter_o + 1'b1;
        end
    end

endmodule

//--- src/pixel_scan.sv
// raster scanner with column/row counters and fixed-point coordinate
// first-pixel and end-of-row flags
`timescale 1ns/1ps

module pixel_scan (
    input  logic                                      out_stream_aclk,
    input  logic                                      axi_resetn,
    input  logic                                      run_i,
    input  logic                                      advance_i,
    input  logic signed [fractal_pkg::DATA_WIDTH-1:0] start_x_i,
    input  logic signed [fractal_pkg::DATA_WIDTH-1:0] start_y_i,
    input  logic signed [fractal_pkg::DATA_WIDTH-1:0] step_i,
    input  logic [fractal_pkg::COORD_WIDTH-1:0]       size_x_i,
    input  logic [fractal_pkg::COORD_WIDTH-1:0]       size_y_i,
    output logic signed [fractal_pkg::DATA_WIDTH-1:0] c_re_o,
    output logic signed [fractal_pkg::DATA_WIDTH-1:0] c_im_o,
    output logic                                      first_o,
    output logic                                      last_x_o
);

    logic [fractal_pkg::COORD_WIDTH-1:0] col;
    logic [fractal_pkg::COORD_WIDTH-1:0] row;
    logic                                last_y;

    assign first_o  = (col == '0) && (row == '0);
    assign last_x_o = (col == size_x_i - 1'b1);
    assign last_y   = (row == size_y_i - 1'b1);

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn || !run_i) begin
            col    <= '0;
            row    <= '0;
            c_re_o <= start_x_i;                      // park on the start point
            c_im_o <= start_y_i;
        end else if (advance_i) begin
            if (last_x_o) begin
                col    <= '0;
                c_re_o <= start_x_i;
                if (last_y) begin                     // frame wraps
                    row    <= '0;
                    c_im_o <= start_y_i;
                end else begin
                    row    <= row + 1'b1;
                    c_im_o <= c_im_o - step_i;        // rows go downward
                end
            end else begin
                col    <= col + 1'b1;
                c_re_o <= c_re_o + step_i;
            end
        end
    end

endmodule

//--- src/axil_regfile.sv
// AXI-Lite slave over eight 32-bit registers
// write side takes address and data in any order, read side fetches then holds
// configuration fields decoded from the registers
`timescale 1ns/1ps

module axil_regfile (
    input  logic                                   out_stream_aclk,
    input  logic                                   axi_resetn,
    input  logic [fractal_pkg::AXIL_ADDR_WIDTH-1:0] s_axi_lite_awaddr_i,
    input  logic                                   s_axi_lite_awvalid_i,
    output logic                                   s_axi_lite_awready_o,
    input  logic [31:0]                            s_axi_lite_wdata_i,
    input  logic                                   s_axi_lite_wvalid_i,
    output logic                                   s_axi_lite_wready_o,
    output logic                                   s_axi_lite_bvalid_o,
    output logic [1:0]                             s_axi_lite_bresp_o,
    input  logic                                   s_axi_lite_bready_i,
    input  logic [fractal_pkg::AXIL_ADDR_WIDTH-1:0] s_axi_lite_araddr_i,
    input  logic                                   s_axi_lite_arvalid_i,
    output logic                                   s_axi_lite_arready_o,
    output logic                                   s_axi_lite_rvalid_o,
    output logic [31:0]                            s_axi_lite_rdata_o,
    output logic [1:0]                             s_axi_lite_rresp_o,
    input  logic                                   s_axi_lite_rready_i,
    output logic                                   run_o,
    output logic [fractal_pkg::DATA_WIDTH-1:0]      start_x_o,
    output logic [fractal_pkg::DATA_WIDTH-1:0]      start_y_o,
    output logic [fractal_pkg::DATA_WIDTH-1:0]      step_o,
    output logic [fractal_pkg::ITER_WIDTH-1:0]      max_iter_o,
    output logic [fractal_pkg::COORD_WIDTH-1:0]     size_x_o,
    output logic [fractal_pkg::COORD_WIDTH-1:0]     size_y_o
);

    logic [31:0]                        regs [fractal_pkg::REG_COUNT];
    logic [fractal_pkg::REG_AWIDTH-1:0] wr_addr;
    logic [fractal_pkg::REG_AWIDTH-1:0] rd_addr;
    logic [31:0]                        wr_data;
    logic                               aw_held;
    logic                               w_held;
    logic                               rd_fetch;

    //////////////////////////////////////////////////////////////////////
    // write side
    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            aw_held             <= 1'b0;
            w_held              <= 1'b0;
            s_axi_lite_bvalid_o <= 1'b0;
            for (int i = 0; i < fractal_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (s_axi_lite_awready_o && s_axi_lite_awvalid_i) begin
                aw_held <= 1'b1;
                wr_addr <= s_axi_lite_awaddr_i[2 +: fractal_pkg::REG_AWIDTH]; // word index
            end
            if (s_axi_lite_wready_o && s_axi_lite_wvalid_i) begin
                w_held  <= 1'b1;
                wr_data <= s_axi_lite_wdata_i;
            end
            if (aw_held && w_held) begin
                regs[wr_addr]       <= wr_data;
                aw_held             <= 1'b0;
                w_held              <= 1'b0;
                s_axi_lite_bvalid_o <= 1'b1;
            end
            if (s_axi_lite_bvalid_o && s_axi_lite_bready_i) begin
                s_axi_lite_bvalid_o <= 1'b0;
            end
        end
    end

    assign s_axi_lite_awready_o = !aw_held && !s_axi_lite_bvalid_o;
    assign s_axi_lite_wready_o  = !w_held && !s_axi_lite_bvalid_o;
    assign s_axi_lite_bresp_o   = fractal_pkg::AXI_RESP_OKAY;

    //////////////////////////////////////////////////////////////////////
    // read side, capture then fetch then hold
    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            rd_fetch            <= 1'b0;
            s_axi_lite_rvalid_o <= 1'b0;
        end else begin
            if (s_axi_lite_arready_o && s_axi_lite_arvalid_i) begin
                rd_fetch <= 1'b1;
                rd_addr  <= s_axi_lite_araddr_i[2 +: fractal_pkg::REG_AWIDTH];
            end
            if (rd_fetch) begin
                rd_fetch            <= 1'b0;
                s_axi_lite_rvalid_o <= 1'b1;
                s_axi_lite_rdata_o  <= regs[rd_addr];
            end
            if (s_axi_lite_rvalid_o && s_axi_lite_rready_i) begin
                s_axi_lite_rvalid_o <= 1'b0;
            end
        end
    end

    assign s_axi_lite_arready_o = !rd_fetch && !s_axi_lite_rvalid_o;
    assign s_axi_lite_rresp_o   = fractal_pkg::AXI_RESP_OKAY;

    // view configuration
    assign run_o      = regs[fractal_pkg::REG_CTRL][0];
    assign start_x_o  = regs[fractal_pkg::REG_START_X][fractal_pkg::DATA_WIDTH-1:0];
    assign start_y_o  = regs[fractal_pkg::REG_START_Y][fractal_pkg::DATA_WIDTH-1:0];
    assign step_o     = regs[fractal_pkg::REG_STEP][fractal_pkg::DATA_WIDTH-1:0];
    assign max_iter_o = regs[fractal_pkg::REG_MAX_ITER][fractal_pkg::ITER_WIDTH-1:0];
    assign size_x_o   = regs[fractal_pkg::REG_SIZE][fractal_pkg::COORD_WIDTH-1:0];
    assign size_y_o   = regs[fractal_pkg::REG_SIZE][2*fractal_pkg::COORD_WIDTH-1:
                                                    fractal_pkg::COORD_WIDTH];

endmodule

//--- src/fractal_pkg.sv
// shared widths, counts and register map of the fractal pixel generator
// AXI response code and escape radius for the cores
package fractal_pkg;

    localparam int DATA_WIDTH      = 32;
    localparam int FRAC_BITS       = 24;    // 8.24 coordinates
    localparam int ITER_WIDTH      = 16;
    localparam int CORE_COUNT      = 4;
    localparam int CORE_IDX_WIDTH  = $clog2(CORE_COUNT);
    localparam int COORD_WIDTH     = 16;

    //////////////////////////////////////////////////////////////////////
    // register map
    localparam int REG_COUNT       = 8;
    localparam int REG_AWIDTH      = 3;
    localparam int AXIL_ADDR_WIDTH = 8;
    localparam int REG_CTRL        = 0;     // bit 0 run
    localparam int REG_START_X     = 1;
    localparam int REG_START_Y     = 2;
    localparam int REG_STEP        = 3;
    localparam int REG_MAX_ITER    = 4;
    localparam int REG_SIZE        = 5;     // cols low, rows high

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // |z|^2 limit of 4.0, sized like the magnitude sum in the cores
    localparam logic [2*DATA_WIDTH-FRAC_BITS:0] ESCAPE_LIMIT = 4 << FRAC_BITS;

endpackage
